/* hw/core_config.svh */
// build constants for the RV32I core
// included by the RTL files that need the reset PC, the NOP word or the register count
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'h0001_0000

// addi x0, x0, 0
`define CORE_NOP_INST 32'h0000_0013

`define CORE_REG_COUNT 32

`endif

/* hw/isa_pkg.sv */
// RV32I architectural encodings: opcodes, function codes, instruction views, ALU operations
package isa_pkg;

   typedef enum logic [6:0] {
      opc_op     = 7'b0110011,
      opc_op_imm = 7'b0010011,
      opc_load   = 7'b0000011,
      opc_store  = 7'b0100011,
      opc_branch = 7'b1100011,
      opc_jal    = 7'b1101111,
      opc_jalr   = 7'b1100111,
      opc_lui    = 7'b0110111
   } opcode_e;

   localparam logic [2:0] f3_add_sub = 3'b000;
   localparam logic [2:0] f3_sll     = 3'b001;
   localparam logic [2:0] f3_slt     = 3'b010;
   localparam logic [2:0] f3_sltu    = 3'b011;
   localparam logic [2:0] f3_xor     = 3'b100;
   localparam logic [2:0] f3_srl_sra = 3'b101;
   localparam logic [2:0] f3_or      = 3'b110;
   localparam logic [2:0] f3_and     = 3'b111;
   localparam logic [2:0] f3_beq     = 3'b000;
   localparam logic [2:0] f3_bne     = 3'b001;
   localparam logic [2:0] f3_word    = 3'b010; // lw and sw
   localparam logic [6:0] f7_alt     = 7'b0100000; // sub, sra, srai

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_t; // also carries the B layout

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_fmt_t; // also carries the J layout

   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
      s_fmt_t s_fmt;
      u_fmt_t u_fmt;
   } inst_u;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor,
      alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
   } alu_op_e;

endpackage

/* hw/pipe_pkg.sv */
// microarchitectural types of the pipeline: control bundle, forward selects, stage records
package pipe_pkg;

   import isa_pkg::*;

   typedef enum logic [1:0] {
      res_alu  = 2'd0,
      res_mem  = 2'd1,
      res_pc4  = 2'd2,
      res_imm  = 2'd3
   } result_sel_e;

   typedef enum logic [1:0] {
      fwd_reg = 2'd0,
      fwd_mem = 2'd1,
      fwd_wb  = 2'd2
   } fwd_sel_e;

   typedef struct packed {
      logic        reg_write;
      logic        mem_write;
      logic        mem_read;
      logic        branch;      // beq or bne
      logic        branch_ne;   // inverts the equal test
      logic        jump;
      logic        jalr;
      logic        alu_src_imm;
      alu_op_e     alu_op;
      result_sel_e result_sel;
   } ctrl_t;

   typedef struct packed {
      ctrl_t       ctrl;
      logic [31:0] pc;
      logic [31:0] rs1_data;
      logic [31:0] rs2_data;
      logic [31:0] imm;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [4:0]  rd;
   } id_ex_t;

   typedef struct packed {
      logic        reg_write;
      logic        mem_write;
      logic        mem_read;
      result_sel_e result_sel;
      logic [31:0] alu_y;
      logic [31:0] store_data;
      logic [31:0] pc_plus4;
      logic [31:0] imm;
      logic [4:0]  rd;
   } ex_mem_t;

   typedef struct packed {
      logic        reg_write;
      result_sel_e result_sel;
      logic [31:0] alu_y;
      logic [31:0] mem_data;
      logic [31:0] pc_plus4;
      logic [31:0] imm;
      logic [4:0]  rd;
   } mem_wb_t;

endpackage

/* hw/hazard_if.sv */
// hazard signals between the datapath and the hazard unit
interface hazard_if import pipe_pkg::*; ();

   logic [4:0] rs1_d, rs2_d;     // decode sources
   logic [4:0] rs1_e, rs2_e;     // execute sources
   logic [4:0] rd_e, rd_m, rd_w;
   logic       load_e;
   logic       reg_write_m, reg_write_w;
   logic       redirect_e;       // taken branch or jump

   logic       stall_fd;
   logic       flush_d, flush_e;
   fwd_sel_e   fwd_a, fwd_b;

   modport datapath (
      output rs1_d, rs2_d, rs1_e, rs2_e, rd_e, load_e,
      output rd_m, reg_write_m, rd_w, reg_write_w, redirect_e,
      input  stall_fd, flush_d, flush_e, fwd_a, fwd_b
   );

   modport hazard_unit (
      input  rs1_d, rs2_d, rs1_e, rs2_e, rd_e, load_e,
      input  rd_m, reg_write_m, rd_w, reg_write_w, redirect_e,
      output stall_fd, flush_d, flush_e, fwd_a, fwd_b
   );

endinterface

/* hw/inst_decoder.sv */
// instruction decoder for the decode stage
// turns one RV32I word into a control bundle and a sign-extended immediate
module inst_decoder import isa_pkg::*, pipe_pkg::*; (
   input  inst_u       inst,
   output ctrl_t       ctrl,
   output logic [31:0] imm
);

   logic [31:0] imm_i, imm_s, imm_b, imm_j, imm_u;

   function automatic alu_op_e alu_sel(input logic [2:0] funct3, input logic alt,
                                       input logic allow_sub);
      case (funct3)
         f3_add_sub: return (alt && allow_sub) ? alu_sub : alu_add;
         f3_sll:     return alu_sll;
         f3_slt:     return alu_slt;
         f3_sltu:    return alu_sltu;
         f3_xor:     return alu_xor;
         f3_srl_sra: return alt ? alu_sra : alu_srl;
         f3_or:      return alu_or;
         default:    return alu_and;
      endcase
   endfunction

   assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
   assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
   assign imm_b = {{19{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi[6], inst.s_fmt.imm_lo[0],
                   inst.s_fmt.imm_hi[5:0], inst.s_fmt.imm_lo[4:1], 1'b0};
   assign imm_j = {{11{inst.u_fmt.imm[19]}}, inst.u_fmt.imm[19], inst.u_fmt.imm[7:0],
                   inst.u_fmt.imm[8], inst.u_fmt.imm[18:9], 1'b0};
   assign imm_u = {inst.u_fmt.imm, 12'b0};

   always_comb begin
      ctrl = '0; // bubble unless recognised
      imm  = imm_i;
      case (inst.r_fmt.opcode)
         opc_op: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = alu_sel(inst.r_fmt.funct3, inst.r_fmt.funct7 == f7_alt, 1'b1);
         end
         opc_op_imm: begin
            ctrl.reg_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.alu_op      = alu_sel(inst.i_fmt.funct3, inst.i_fmt.imm[11:5] == f7_alt, 1'b0);
         end
         opc_load: begin
            ctrl.reg_write   = inst.i_fmt.funct3 == f3_word;
            ctrl.mem_read    = inst.i_fmt.funct3 == f3_word;
            ctrl.alu_src_imm = 1'b1;
            ctrl.result_sel  = res_mem;
         end
         opc_store: begin
            ctrl.mem_write   = inst.s_fmt.funct3 == f3_word;
            ctrl.alu_src_imm = 1'b1;
            imm              = imm_s;
         end
         opc_branch: begin
            ctrl.branch    = inst.s_fmt.funct3 == f3_beq || inst.s_fmt.funct3 == f3_bne;
            ctrl.branch_ne = inst.s_fmt.funct3 == f3_bne;
            ctrl.alu_op    = alu_sub;
            imm            = imm_b;
         end
         opc_jal: begin
            ctrl.reg_write  = 1'b1;
            ctrl.jump       = 1'b1;
            ctrl.result_sel = res_pc4; // link
            imm             = imm_j;
         end
         opc_jalr: begin
            ctrl.reg_write   = 1'b1;
            ctrl.jump        = 1'b1;
            ctrl.jalr        = 1'b1;
            ctrl.alu_src_imm = 1'b1; // target from rs1 + imm
            ctrl.result_sel  = res_pc4;
         end
         opc_lui: begin
            ctrl.reg_write  = 1'b1;
            ctrl.result_sel = res_imm;
            imm             = imm_u;
         end
         default: ;
      endcase
   end

endmodule

/* hw/reg_file.sv */
// integer register file, two read ports and one write port
// a read of the register being written returns the new value
`include "core_config.svh"

module reg_file (
   input  logic        clk,
   input  logic        rst,
   input  logic [4:0]  rs1_addr,
   input  logic [4:0]  rs2_addr,
   input  logic [4:0]  rd_addr,
   input  logic [31:0] rd_data,
   input  logic        rd_we,
   output logic [31:0] rs1_data,
   output logic [31:0] rs2_data
);

   logic [31:0] regs [`CORE_REG_COUNT];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `CORE_REG_COUNT; i++)
            regs[i] <= '0;
      end else if (rd_we && rd_addr != 5'd0) begin
         regs[rd_addr] <= rd_data; // x0 never written
      end
   end

   assign rs1_data = (rs1_addr == 5'd0) ? '0 :
                     (rd_we && rd_addr == rs1_addr) ? rd_data : regs[rs1_addr];
   assign rs2_data = (rs2_addr == 5'd0) ? '0 :
                     (rd_we && rd_addr == rs2_addr) ? rd_data : regs[rs2_addr];

endmodule

/* hw/alu.sv */
// execute-stage ALU: add/sub, logic ops, compares and shifts
// equal feeds branch resolution
module alu import isa_pkg::*; (
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  alu_op_e     op,
   output logic [31:0] y,
   output logic        equal
);

   logic [4:0] shamt;

   assign shamt = b[4:0]; // shifts use low five bits only

   always_comb begin
      case (op)
         alu_add:  y = a + b;
         alu_sub:  y = a - b;
         alu_and:  y = a & b;
         alu_or:   y = a | b;
         alu_xor:  y = a ^ b;
         alu_slt:  y = {31'b0, $signed(a) < $signed(b)};
         alu_sltu: y = {31'b0, a < b};
         alu_sll:  y = a << shamt;
         alu_srl:  y = a >> shamt;
         alu_sra:  y = $unsigned($signed(a) >>> shamt);
         default:  y = a + b;
      endcase
   end

   assign equal = a == b;

endmodule

/* hw/hazard_unit.sv */
// forwarding selects, load-use stall and redirect flush for the pipeline
module hazard_unit import pipe_pkg::*; (
   hazard_if.hazard_unit hz
);

   logic load_use;

   // memory stage is younger so it wins over write-back
   function automatic fwd_sel_e fwd_pick(input logic [4:0] rs, input logic wr_m,
                                         input logic [4:0] rd_m, input logic wr_w,
                                         input logic [4:0] rd_w);
      if (rs == 5'd0)
         return fwd_reg;
      else if (wr_m && rd_m == rs)
         return fwd_mem;
      else if (wr_w && rd_w == rs)
         return fwd_wb;
      else
         return fwd_reg;
   endfunction

   assign hz.fwd_a = fwd_pick(hz.rs1_e, hz.reg_write_m, hz.rd_m, hz.reg_write_w, hz.rd_w);
   assign hz.fwd_b = fwd_pick(hz.rs2_e, hz.reg_write_m, hz.rd_m, hz.reg_write_w, hz.rd_w);

   assign load_use = hz.load_e && hz.rd_e != 5'd0 &&
                     (hz.rd_e == hz.rs1_d || hz.rd_e == hz.rs2_d);

   // a redirect kills the stalled decode, so the PC must move
   assign hz.stall_fd = load_use && !hz.redirect_e;
   assign hz.flush_d  = hz.redirect_e;
   assign hz.flush_e  = load_use || hz.redirect_e; // bubble into execute

endmodule

/* hw/pipeline_core.sv */
// five-stage RV32I core top level: fetch, decode, execute, memory, write-back
// instruction and data memories are combinational and sit outside
`include "core_config.svh"

module pipeline_core import isa_pkg::*, pipe_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   output logic [31:0] imem_addr,
   input  logic [31:0] imem_rdata,
   output logic        dmem_req,
   output logic        dmem_we,
   output logic [31:0] dmem_addr,
   output logic [31:0] dmem_wdata,
   input  logic [31:0] dmem_rdata
);

   logic [31:0] pc_f;
   logic [31:0] pc_d;
   inst_u       inst_d;
   ctrl_t       ctrl_d;
   logic [31:0] imm_d, rs1_data_d, rs2_data_d;
   id_ex_t      ex;
   ex_mem_t     mem;
   mem_wb_t     wb;
   logic [31:0] src_a, rs2_fwd, src_b, alu_y, link_e, target_e;
   logic        alu_eq, redirect_e;
   logic [31:0] mem_fwd, result_w;

   hazard_if hz_if ();

   function automatic logic [31:0] fwd_mux(input fwd_sel_e sel, input logic [31:0] reg_val,
                                           input logic [31:0] mem_val,
                                           input logic [31:0] wb_val);
      case (sel)
         fwd_mem: return mem_val;
         fwd_wb:  return wb_val;
         default: return reg_val;
      endcase
   endfunction

   // fetch
   always_ff @(posedge clk) begin
      if (rst)
         pc_f <= `CORE_RESET_PC;
      else if (redirect_e)
         pc_f <= target_e;
      else if (!hz_if.stall_fd)
         pc_f <= pc_f + 32'd4;
   end

   assign imem_addr = pc_f;

   always_ff @(posedge clk) begin
      if (rst || hz_if.flush_d)
         inst_d <= `CORE_NOP_INST;
      else if (!hz_if.stall_fd)
         inst_d <= imem_rdata;
      if (!hz_if.stall_fd)
         pc_d <= pc_f;
   end

   // decode
   inst_decoder dec_i (.inst(inst_d), .ctrl(ctrl_d), .imm(imm_d));

   reg_file rf_i (
      .clk(clk), .rst(rst),
      .rs1_addr(inst_d.r_fmt.rs1), .rs2_addr(inst_d.r_fmt.rs2),
      .rd_addr(wb.rd), .rd_data(result_w), .rd_we(wb.reg_write),
      .rs1_data(rs1_data_d), .rs2_data(rs2_data_d)
   );

   always_ff @(posedge clk) begin
      ex.pc       <= pc_d;
      ex.rs1_data <= rs1_data_d;
      ex.rs2_data <= rs2_data_d;
      ex.imm      <= imm_d;
      ex.rs1      <= inst_d.r_fmt.rs1;
      ex.rs2      <= inst_d.r_fmt.rs2;
      ex.rd       <= inst_d.r_fmt.rd;
      if (rst || hz_if.flush_e)
         ex.ctrl <= '0; // bubble
      else
         ex.ctrl <= ctrl_d;
   end

   // execute
   assign src_a   = fwd_mux(hz_if.fwd_a, ex.rs1_data, mem_fwd, result_w);
   assign rs2_fwd = fwd_mux(hz_if.fwd_b, ex.rs2_data, mem_fwd, result_w);
   assign src_b   = ex.ctrl.alu_src_imm ? ex.imm : rs2_fwd;

   alu alu_i (.a(src_a), .b(src_b), .op(ex.ctrl.alu_op), .y(alu_y), .equal(alu_eq));

   assign link_e     = ex.pc + 32'd4;
   assign target_e   = ex.ctrl.jalr ? {alu_y[31:1], 1'b0} : ex.pc + ex.imm;
   assign redirect_e = ex.ctrl.jump || (ex.ctrl.branch && (alu_eq ^ ex.ctrl.branch_ne));

   always_ff @(posedge clk) begin
      mem.result_sel <= ex.ctrl.result_sel;
      mem.alu_y      <= alu_y;
      mem.store_data <= rs2_fwd;
      mem.pc_plus4   <= link_e;
      mem.imm        <= ex.imm;
      mem.rd         <= ex.rd;
      mem.reg_write  <= rst ? 1'b0 : ex.ctrl.reg_write;
      mem.mem_write  <= rst ? 1'b0 : ex.ctrl.mem_write;
      mem.mem_read   <= rst ? 1'b0 : ex.ctrl.mem_read;
   end

   // memory
   assign dmem_req   = mem.mem_read || mem.mem_write;
   assign dmem_we    = mem.mem_write;
   assign dmem_addr  = mem.alu_y;
   assign dmem_wdata = mem.store_data;

   // load data never forwards from here, the load-use stall covers it
   assign mem_fwd = (mem.result_sel == res_pc4) ? mem.pc_plus4 :
                    (mem.result_sel == res_imm) ? mem.imm : mem.alu_y;

   always_ff @(posedge clk) begin
      wb.result_sel <= mem.result_sel;
      wb.alu_y      <= mem.alu_y;
      wb.mem_data   <= dmem_rdata;
      wb.pc_plus4   <= mem.pc_plus4;
      wb.imm        <= mem.imm;
      wb.rd         <= mem.rd;
      wb.reg_write  <= rst ? 1'b0 : mem.reg_write;
   end

   // write-back
   always_comb begin
      case (wb.result_sel)
         res_mem: result_w = wb.mem_data;
         res_pc4: result_w = wb.pc_plus4;
         res_imm: result_w = wb.imm; // lui
         default: result_w = wb.alu_y;
      endcase
   end

   // hazard unit hookup
   assign hz_if.rs1_d       = inst_d.r_fmt.rs1;
   assign hz_if.rs2_d       = inst_d.r_fmt.rs2;
   assign hz_if.rs1_e       = ex.rs1;
   assign hz_if.rs2_e       = ex.rs2;
   assign hz_if.rd_e        = ex.rd;
   assign hz_if.load_e      = ex.ctrl.mem_read;
   assign hz_if.rd_m        = mem.rd;
   assign hz_if.reg_write_m = mem.reg_write;
   assign hz_if.rd_w        = wb.rd;
   assign hz_if.reg_write_w = wb.reg_write;
   assign hz_if.redirect_e  = redirect_e;

   hazard_unit hz_i (.hz(hz_if.hazard_unit));

endmodule

/* verification/core_ref_model.sv */
// instruction-set model of the RV32I subset, used by the core testbench
// runs the program from its own memories and records every store in program order
`include "core_config.svh"

module core_ref_model;
   timeunit 1ns;
   timeprecision 100ps;

   logic [31:0] imem [512];
   logic [31:0] dmem [256];
   logic [31:0] exp_addr [1024];
   logic [31:0] exp_data [1024];
   int          exp_count;

   function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return {31'b0, $signed(a) < $signed(b)};
         3'd3:    return {31'b0, a < b};
         3'd4:    return a ^ b;
         3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   task automatic run(input logic [31:0] done_addr, input int max_steps);
      logic [31:0] x [32];
      logic [31:0] pc, pc_off, inst, a, b, addr, wval, next_pc;
      logic [31:0] imm_i, imm_s, imm_b, imm_j;
      logic [4:0]  rd;
      logic [2:0]  f3;
      logic        wen, done;
      int          steps;
      for (int r = 0; r < 32; r++)
         x[r] = '0;
      pc = `CORE_RESET_PC;
      exp_count = 0;
      done = 1'b0;
      steps = 0;
      while (!done && steps < max_steps) begin
         pc_off = pc - `CORE_RESET_PC;
         inst = imem[pc_off[10:2]];
         rd = inst[11:7];
         f3 = inst[14:12];
         a = x[inst[19:15]];
         b = x[inst[24:20]];
         imm_i = {{20{inst[31]}}, inst[31:20]};
         imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
         imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
         imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
         next_pc = pc + 32'd4;
         wen = 1'b1;
         wval = '0;
         case (inst[6:0])
            7'h33: wval = alu_calc(f3, inst[30], a, b); // register-register
            7'h13: wval = alu_calc(f3, f3 == 3'd5 && inst[30], a, imm_i); // only srai alters
            7'h03: begin
               addr = a + imm_i;
               wval = dmem[addr[9:2]];
            end
            7'h23: begin
               wen = 1'b0;
               addr = a + imm_s;
               dmem[addr[9:2]] = b;
               exp_addr[exp_count] = addr;
               exp_data[exp_count] = b;
               exp_count++;
               done = addr == done_addr;
            end
            7'h63: begin
               wen = 1'b0;
               if ((a == b) != f3[0]) // beq when f3 is 0, bne when 1
                  next_pc = pc + imm_b;
            end
            7'h6f: begin
               wval = pc + 32'd4;
               next_pc = pc + imm_j;
            end
            7'h67: begin
               wval = pc + 32'd4;
               next_pc = (a + imm_i) & ~32'd1;
            end
            7'h37: wval = {inst[31:12], 12'b0};
            default: wen = 1'b0;
         endcase
         if (wen && rd != 5'd0)
            x[rd] = wval; // x0 stays zero
         pc = next_pc;
         steps++;
      end
   endtask

endmodule

/* verification/core_tb.sv */
// testbench for the five-stage RV32I core
// runs one random program on the core and on the ISA model and compares the store streams
`include "core_config.svh"

module core_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] dump_base = 32'h100;
   localparam logic [31:0] done_addr = 32'h200;

   logic        clk, rst;
   logic [31:0] imem_addr, imem_rdata, imem_off;
   logic        dmem_req, dmem_we;
   logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
   logic [31:0] imem [512];
   logic [31:0] dmem [256];
   logic [4:0]  recent [3]; // last three destinations
   int          seed = 8298;
   int          prog_len;
   int          got_count = 0;
   logic        done_seen = 1'b0;

   pipeline_core dut_i (
      .clk(clk), .rst(rst),
      .imem_addr(imem_addr), .imem_rdata(imem_rdata),
      .dmem_req(dmem_req), .dmem_we(dmem_we),
      .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata)
   );

   core_ref_model ref_i ();

   assign imem_off   = imem_addr - `CORE_RESET_PC;
   assign imem_rdata = imem[imem_off[10:2]];
   assign dmem_rdata = (dmem_req && !dmem_we) ? dmem[dmem_addr[9:2]] : 'x; // read only on req

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      if (dmem_req && dmem_we)
         dmem[dmem_addr[9:2]] <= dmem_wdata;
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("FAILED %s: expected %h, actual %h", name, expected, actual);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   function automatic int rnd(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic [4:0] pick_src();
      if (rnd(2) == 0)
         return recent[rnd(3)]; // bias toward forwarding
      return 5'(rnd(32));
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
   endfunction

   function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, 7'h37};
   endfunction

   task automatic emit(input logic [31:0] word);
      imem[prog_len] = word;
      prog_len++;
   endtask

   task automatic note_dest(input logic [4:0] rd);
      recent[2] = recent[1];
      recent[1] = recent[0];
      recent[0] = rd;
   endtask

   task automatic gen_program();
      logic [4:0]  rd, rs1, rs2;
      logic [2:0]  f3;
      logic [11:0] imm;
      int          kind, skip;
      prog_len = 0;
      // x31 holds the code base for jalr, every other register gets a random value
      for (int r = 1; r < 32; r++) begin
         emit(enc_u(r == 31 ? 20'(`CORE_RESET_PC >> 12) : 20'(rnd(1 << 20)), 5'(r)));
         emit(enc_i(r == 31 ? 12'h0 : 12'(rnd(4096)), 5'(r), 3'b000, 5'(r), 7'h13));
      end
      recent = '{5'd30, 5'd29, 5'd28};
      for (int n = 0; n < 200; n++) begin
         rd = 5'(rnd(31)); // never x31
         rs1 = pick_src();
         rs2 = pick_src();
         f3 = 3'(rnd(8));
         skip = rnd(4) + 2; // jumps over 1 to 4 instructions
         kind = rnd(8);
         case (kind)
            0: emit(enc_r(((f3 == 3'd0 || f3 == 3'd5) && rnd(2)) ? 7'h20 : 7'h00,
                          rs2, rs1, f3, rd));
            1: begin
               imm = 12'(rnd(4096));
               if (f3 == 3'd1)
                  imm = 12'(rnd(32));
               if (f3 == 3'd5)
                  imm = {rnd(2) ? 7'h20 : 7'h00, 5'(rnd(32))};
               emit(enc_i(imm, rs1, f3, rd, 7'h13));
            end
            2: emit(enc_i(12'(4 * rnd(64)), 5'd0, 3'b010, rd, 7'h03)); // lw
            3: emit(enc_s(12'(4 * rnd(64)), rs2, 5'd0));
            4: emit(enc_b(13'(4 * skip), rnd(3) == 0 ? rs1 : rs2, rs1, 3'(rnd(2))));
            5: emit(enc_j(21'(4 * skip), rd));
            6: begin
               emit(enc_u(20'(`CORE_RESET_PC >> 12), 5'd31));
               imm = 12'(4 * (prog_len + skip)) | 12'(rnd(2)); // odd target tests bit 0 drop
               emit(enc_i(imm, 5'd31, 3'b000, rd, 7'h67));
            end
            default: emit(enc_u(20'(rnd(1 << 20)), rd));
         endcase
         if (kind != 3 && kind != 4)
            note_dest(rd);
      end
      for (int r = 0; r < 32; r++)
         emit(enc_s(12'(dump_base + 4 * r), 5'(r), 5'd0)); // register dump
      emit(enc_s(12'(done_addr), 5'd0, 5'd0));
      emit(enc_j(21'd0, 5'd0)); // park
   endtask

   initial begin
      int cyc;
      rst = 1'b1;
      for (int i = 0; i < 512; i++)
         imem[i] = {12'(i), 20'h00013}; // addi x0 with an address-tagged immediate
      for (int i = 0; i < 256; i++)
         dmem[i] = {~8'(i), 8'(i), 8'(i), ~8'(i)};
      gen_program();
      for (int i = 0; i < 512; i++)
         ref_i.imem[i] = imem[i];
      for (int i = 0; i < 256; i++)
         ref_i.dmem[i] = dmem[i];
      ref_i.run(done_addr, 5000);
      if (ref_i.exp_count == 0 || ref_i.exp_addr[ref_i.exp_count - 1] != done_addr) begin
         $display("the reference model never reached the done store");
         $display("TEST FAILED");
         $fatal(1);
      end
      for (int c = 0; c < 10; c++) begin
         @(negedge clk);
         check_value("reset dmem_we", 32'd0, 32'(dmem_we));
         check_value("reset dmem_req", 32'd0, 32'(dmem_req));
      end
      check_value("reset imem_addr", `CORE_RESET_PC, imem_addr);
      rst = 1'b0;
      @(negedge clk);
      check_value("first cycle dmem_we", 32'd0, 32'(dmem_we));
      check_value("first cycle dmem_req", 32'd0, 32'(dmem_req));
      for (cyc = 0; cyc < 5000 && !done_seen; cyc++)
         @(posedge clk);
      if (!done_seen) begin
         $display("timeout: the core never finished the program within 5000 cycles");
         $display("TEST FAILED");
         $fatal(1);
      end else begin
         repeat (4) @(posedge clk); // pipeline drains, no store may follow the done store
         $display("TEST PASSED");
         $finish;
      end
   end

   // store stream against the model, in order
   always @(negedge clk) begin
      if (dmem_we === 1'b1) begin
         if (got_count >= ref_i.exp_count) begin
            $display("the core made more stores than the reference model");
            $display("TEST FAILED");
            $fatal(1);
         end
         check_value($sformatf("store %0d dmem_req", got_count), 32'd1, 32'(dmem_req));
         check_value($sformatf("store %0d address", got_count),
                     ref_i.exp_addr[got_count], dmem_addr);
         check_value($sformatf("store %0d data", got_count),
                     ref_i.exp_data[got_count], dmem_wdata);
         if (dmem_addr == done_addr)
            done_seen = 1'b1;
         got_count++;
      end
   end

endmodule

/* project.f */
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/hazard_if.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/hazard_unit.sv
hw/pipeline_core.sv
verification/core_ref_model.sv
verification/core_tb.sv
